/* design/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    localparam int XLEN             = 32;
    localparam int HIST_LEN         = 16;
    localparam int TAG_WIDTH        = 10;
    localparam int PARTIAL_TAG_BITS = 6;  // upper tag bits used for a hit
    localparam int BTB_TAG_WIDTH    = 22;

    typedef logic [XLEN-1:0]     xlen_t;
    typedef logic [HIST_LEN-1:0] hist_t;
    typedef logic [1:0]          ctr_t;

    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT   = 2'b01;
    localparam ctr_t CTR_WEAK_T    = 2'b10;
    localparam ctr_t CTR_STRONG_T  = 2'b11;

    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    typedef enum logic [1:0] {
        prov_bimodal,
        prov_t0,
        prov_t1
    } provider_e;

    // jalr through ra or t0 counts as a return
    function automatic logic is_return(input xlen_t inst);
        return (inst[6:0] == op_jalr) && ((inst[19:15] == 5'd1) || (inst[19:15] == 5'd5));
    endfunction

    // saturating step toward the outcome
    function automatic ctr_t ctr_next(input ctr_t c, input logic taken);
        if (taken)
            return (c == CTR_STRONG_T) ? c : c + 2'd1;
        return (c == CTR_STRONG_NT) ? c : c - 2'd1;
    endfunction

endpackage

`default_nettype wire

/* design/bpu_update_if.sv */
`default_nettype none

// resolved branch info from execute, used to train all tables
interface bpu_update_if;
    import bpu_pkg::*;

    logic  valid;
    logic  taken;
    logic  pdt_true;   // prediction matched the outcome
    xlen_t pc;
    hist_t history;    // history seen at prediction time
    xlen_t target;

    modport source (
        output valid, taken, pdt_true, pc, history, target
    );

    modport sink (
        input valid, taken, pdt_true, pc, history, target
    );

endinterface

`default_nettype wire

/* design/tagged_table.sv */
`default_nettype none

module tagged_table #(
    parameter int ENTRIES        = 256,
    parameter int INDEX_HIST_LSB = 0,
    parameter int TAG_HIST_LSB   = 0
) (
    input  wire               clk,
    input  wire               rst,
    input  bpu_pkg::xlen_t    pc_i,
    input  bpu_pkg::hist_t    history_i,
    output logic              hit_o,
    output bpu_pkg::ctr_t     ctr_o,
    bpu_update_if.sink        upd,
    output logic              upd_hit_o,
    output logic              upd_tag_eq_o,
    input  wire               train_i,
    input  wire               set_strong_i,
    input  wire               alloc_i
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int PT_LSB = TAG_WIDTH - PARTIAL_TAG_BITS;

    logic                 valid_q [ENTRIES];
    logic [TAG_WIDTH-1:0] tag_q   [ENTRIES];
    ctr_t                 ctr_q   [ENTRIES];

    logic [IDX_W-1:0]     lk_idx, up_idx;
    logic [TAG_WIDTH-1:0] lk_tag, up_tag;

    // folded pc and history slices
    assign lk_idx = pc_i[IDX_W-1:0] ^ history_i[INDEX_HIST_LSB +: IDX_W];
    assign lk_tag = pc_i[IDX_W +: TAG_WIDTH] ^ history_i[TAG_HIST_LSB +: TAG_WIDTH];
    assign up_idx = upd.pc[IDX_W-1:0] ^ upd.history[INDEX_HIST_LSB +: IDX_W];
    assign up_tag = upd.pc[IDX_W +: TAG_WIDTH] ^ upd.history[TAG_HIST_LSB +: TAG_WIDTH];

    assign hit_o = valid_q[lk_idx] &&
                   (tag_q[lk_idx][TAG_WIDTH-1:PT_LSB] == lk_tag[TAG_WIDTH-1:PT_LSB]);
    assign ctr_o = ctr_q[lk_idx];

    assign upd_hit_o = valid_q[up_idx] &&
                       (tag_q[up_idx][TAG_WIDTH-1:PT_LSB] == up_tag[TAG_WIDTH-1:PT_LSB]);
    assign upd_tag_eq_o = valid_q[up_idx] && (tag_q[up_idx] == up_tag);  // full compare

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                tag_q[i]   <= '0;
                ctr_q[i]   <= CTR_WEAK_NT;
            end
        end else if (upd.valid) begin
            if (alloc_i) begin
                valid_q[up_idx] <= 1'b1;
                tag_q[up_idx]   <= up_tag;
                ctr_q[up_idx]   <= upd.taken ? CTR_WEAK_T : CTR_WEAK_NT;
            end else if (set_strong_i) begin
                ctr_q[up_idx] <= upd.taken ? CTR_STRONG_T : CTR_STRONG_NT;
            end else if (train_i) begin
                ctr_q[up_idx] <= ctr_next(ctr_q[up_idx], upd.taken);
            end
        end
    end

endmodule

`default_nettype wire

/* design/direction_predictor.sv */
`default_nettype none

module direction_predictor #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGGED_ENTRIES  = 256
) (
    input  wire            clk,
    input  wire            rst,
    input  bpu_pkg::xlen_t pc_i,
    input  bpu_pkg::hist_t history_i,
    bpu_update_if.sink     upd,
    output logic           taken_o
);
    import bpu_pkg::*;

    localparam int BM_W = $clog2(BIMODAL_ENTRIES);

    ctr_t bm_q [BIMODAL_ENTRIES];

    logic [BM_W-1:0] bm_idx, bm_up_idx;
    logic t0_hit, t1_hit, t0_up_hit, t1_up_hit, t0_tag_eq, t1_tag_eq;
    ctr_t t0_ctr, t1_ctr;
    provider_e lk_prov, up_prov;
    logic t0_train, t1_train, t0_strong, t1_strong, t0_alloc, t1_alloc;
    logic bm_wrong;

    assign bm_idx    = pc_i[BM_W:1];
    assign bm_up_idx = upd.pc[BM_W:1];

    // longest history wins
    assign lk_prov = t1_hit ? prov_t1 : (t0_hit ? prov_t0 : prov_bimodal);
    assign up_prov = t1_up_hit ? prov_t1 : (t0_up_hit ? prov_t0 : prov_bimodal);

    always_comb begin
        case (lk_prov)
            prov_t1: taken_o = t1_ctr[1];
            prov_t0: taken_o = t0_ctr[1];
            default: taken_o = bm_q[bm_idx][1];
        endcase
    end

    assign t1_train  = (up_prov == prov_t1) && upd.pdt_true;
    assign t1_strong = (up_prov == prov_t1) && !upd.pdt_true;
    assign t0_train  = (up_prov == prov_t0) && upd.pdt_true;
    assign t0_strong = (up_prov == prov_t0) && !upd.pdt_true;

    // base mispredict allocates, T1 preferred
    assign bm_wrong = (up_prov == prov_bimodal) && !upd.pdt_true;
    assign t1_alloc = bm_wrong && !t1_tag_eq;
    assign t0_alloc = bm_wrong && t1_tag_eq && !t0_tag_eq;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BIMODAL_ENTRIES; i++)
                bm_q[i] <= CTR_WEAK_NT;
        end else if (upd.valid) begin
            bm_q[bm_up_idx] <= ctr_next(bm_q[bm_up_idx], upd.taken);  // always trains
        end
    end

    tagged_table #(
        .ENTRIES(TAGGED_ENTRIES), .INDEX_HIST_LSB(0), .TAG_HIST_LSB(6)
    ) t0 (
        .clk(clk), .rst(rst), .pc_i(pc_i), .history_i(history_i),
        .hit_o(t0_hit), .ctr_o(t0_ctr), .upd(upd),
        .upd_hit_o(t0_up_hit), .upd_tag_eq_o(t0_tag_eq),
        .train_i(t0_train), .set_strong_i(t0_strong), .alloc_i(t0_alloc)
    );

    tagged_table #(
        .ENTRIES(TAGGED_ENTRIES), .INDEX_HIST_LSB(8), .TAG_HIST_LSB(0)
    ) t1 (
        .clk(clk), .rst(rst), .pc_i(pc_i), .history_i(history_i),
        .hit_o(t1_hit), .ctr_o(t1_ctr), .upd(upd),
        .upd_hit_o(t1_up_hit), .upd_tag_eq_o(t1_tag_eq),
        .train_i(t1_train), .set_strong_i(t1_strong), .alloc_i(t1_alloc)
    );

endmodule

`default_nettype wire

/* design/btb.sv */
`default_nettype none

module btb #(
    parameter int ENTRIES = 256
) (
    input  wire            clk,
    input  wire            rst,
    input  bpu_pkg::xlen_t pc_i,
    output logic           hit_o,
    output bpu_pkg::xlen_t target_o,
    bpu_update_if.sink     upd
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);

    logic                     valid_q  [ENTRIES];
    logic [BTB_TAG_WIDTH-1:0] tag_q    [ENTRIES];
    xlen_t                    target_q [ENTRIES];

    logic [IDX_W-1:0]         lk_idx, up_idx;
    logic [BTB_TAG_WIDTH-1:0] lk_tag, up_tag;

    assign lk_idx = pc_i[IDX_W+1:2];  // word aligned
    assign lk_tag = pc_i[XLEN-1 -: BTB_TAG_WIDTH];
    assign up_idx = upd.pc[IDX_W+1:2];
    assign up_tag = upd.pc[XLEN-1 -: BTB_TAG_WIDTH];

    assign hit_o    = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign target_o = target_q[lk_idx];

    // only taken branches are worth remembering
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i]  <= 1'b0;
                tag_q[i]    <= '0;
                target_q[i] <= '0;
            end
        end else if (upd.valid && upd.taken) begin
            valid_q[up_idx]  <= 1'b1;
            tag_q[up_idx]    <= up_tag;
            target_q[up_idx] <= upd.target;
        end
    end

endmodule

`default_nettype wire

/* design/return_stack.sv */
`default_nettype none

module return_stack #(
    parameter int DEPTH = 64
) (
    input  wire            clk,
    input  wire            rst,
    input  wire            push_i,
    input  bpu_pkg::xlen_t push_data_i,
    input  wire            pop_i,
    output bpu_pkg::xlen_t top_o,
    output logic           empty_o
);
    import bpu_pkg::*;

    localparam int PTR_W = $clog2(DEPTH) + 1;  // one extra bit to hold DEPTH

    xlen_t            stack_q [DEPTH];
    logic [PTR_W-1:0] sp_q;      // next free slot
    logic [PTR_W-1:0] sp_pop;
    logic [PTR_W-2:0] top_idx;
    logic             pop_ok, push_ok;

    // pop first, then push lands on the freed slot
    assign pop_ok  = pop_i && (sp_q != '0);
    assign sp_pop  = pop_ok ? sp_q - 1'b1 : sp_q;
    assign push_ok = push_i && (sp_pop < PTR_W'(DEPTH));  // full stack drops the push

    assign top_idx = sp_q[PTR_W-2:0] - 1'b1;
    assign top_o   = stack_q[top_idx];
    assign empty_o = (sp_q == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sp_q <= '0;
        else
            sp_q <= push_ok ? sp_pop + 1'b1 : sp_pop;
    end

    always_ff @(posedge clk) begin
        if (push_ok)
            stack_q[sp_pop[PTR_W-2:0]] <= push_data_i;
    end

endmodule

`default_nettype wire

/* design/bpu.sv */
`default_nettype none

module bpu #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGGED_ENTRIES  = 256,
    parameter int BTB_ENTRIES     = 256,
    parameter int RAS_DEPTH       = 64
) (
    input  wire            clk,
    input  wire            rst,
    input  bpu_pkg::xlen_t if_pc_i,
    input  bpu_pkg::xlen_t if_inst_i,
    input  wire            ex_valid_i,
    input  wire            ex_taken_i,
    input  wire            ex_pdt_true_i,
    input  wire            ex_stall_i,
    input  bpu_pkg::xlen_t ex_pc_i,
    input  bpu_pkg::xlen_t ex_target_i,
    input  bpu_pkg::xlen_t ex_inst_i,
    input  bpu_pkg::hist_t ex_history_i,
    input  wire            id_push_i,
    input  bpu_pkg::xlen_t id_push_data_i,
    input  wire            id_stall_i,
    output logic           is_branch_o,
    output logic           pred_taken_o,
    output bpu_pkg::xlen_t pred_pc_o,
    output bpu_pkg::hist_t history_o
);
    import bpu_pkg::*;

    opcode_e op;
    logic    is_br, is_jal, is_jalr, is_ret;
    hist_t   history_q;
    logic    ras_push, ras_pop, ras_empty;
    xlen_t   ras_top;
    logic    dir_taken, btb_hit;
    xlen_t   btb_target;
    xlen_t   pc_plus4, j_imm, b_imm;

    bpu_update_if upd_bus ();

    assign upd_bus.valid    = ex_valid_i;
    assign upd_bus.taken    = ex_taken_i;
    assign upd_bus.pdt_true = ex_pdt_true_i;
    assign upd_bus.pc       = ex_pc_i;
    assign upd_bus.history  = ex_history_i;
    assign upd_bus.target   = ex_target_i;

    // predecode
    assign op      = opcode_e'(if_inst_i[6:0]);
    assign is_br   = (op == op_branch);
    assign is_jal  = (op == op_jal);
    assign is_jalr = (op == op_jalr);
    assign is_ret  = is_return(if_inst_i);

    assign pc_plus4 = if_pc_i + 32'd4;
    assign j_imm = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};
    assign b_imm = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};

    // stack strobes, a stalled pipe holds the stack
    assign ras_push = id_push_i && !id_stall_i && !ex_stall_i;
    assign ras_pop  = ex_valid_i && ex_taken_i && is_return(ex_inst_i) && !ex_stall_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            history_q <= '0;
        else if (ex_valid_i)
            history_q <= {history_q[HIST_LEN-2:0], ex_taken_i};
    end

    assign history_o = history_q;

    always_comb begin
        is_branch_o  = is_br || is_jal || is_jalr;
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;
        if (is_ret) begin
            if (ras_push) begin
                pred_taken_o = 1'b1;
                pred_pc_o    = id_push_data_i;  // call in decode right now
            end else if (!ras_empty) begin
                pred_taken_o = 1'b1;
                pred_pc_o    = ras_top;
            end
        end else if (is_jal) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit ? btb_target : if_pc_i + j_imm;
        end else if (is_br || is_jalr) begin
            pred_taken_o = dir_taken;
            if (dir_taken) begin
                if (btb_hit)
                    pred_pc_o = btb_target;
                else if (is_br)
                    pred_pc_o = if_pc_i + b_imm;
            end
        end
    end

    direction_predictor #(
        .BIMODAL_ENTRIES(BIMODAL_ENTRIES), .TAGGED_ENTRIES(TAGGED_ENTRIES)
    ) u_dir (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .history_i(history_q),
        .upd(upd_bus), .taken_o(dir_taken)
    );

    btb #(.ENTRIES(BTB_ENTRIES)) u_btb (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .hit_o(btb_hit),
        .target_o(btb_target), .upd(upd_bus)
    );

    return_stack #(.DEPTH(RAS_DEPTH)) u_ras (
        .clk(clk), .rst(rst), .push_i(ras_push), .push_data_i(id_push_data_i),
        .pop_i(ras_pop), .top_o(ras_top), .empty_o(ras_empty)
    );

endmodule

`default_nettype wire

/* tb/bpu_tb.sv */
`default_nettype none

module bpu_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import bpu_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 4;
    localparam int    NCOLS        = 17;  // words per test step
    localparam int    MAX_STEPS    = 64;
    localparam xlen_t END_MARK     = 32'hffff_ffff;

    logic  clk, rst;
    xlen_t if_pc_i, if_inst_i;
    logic  ex_valid_i, ex_taken_i, ex_pdt_true_i, ex_stall_i;
    xlen_t ex_pc_i, ex_target_i, ex_inst_i;
    hist_t ex_history_i;
    logic  id_push_i, id_stall_i;
    xlen_t id_push_data_i;
    logic  is_branch_o, pred_taken_o;
    xlen_t pred_pc_o;
    hist_t history_o;

    xlen_t test_mem [MAX_STEPS*NCOLS];
    int    n_steps;
    int    cur_step;
    int    cycle_cnt;
    int    max_cycles = 0;

    bpu uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %0t ns step %0d: %s expected %b, got %b",
                               $time, cur_step, name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %0t ns step %0d: %s expected %h, got %h",
                               $time, cur_step, name, expected, actual));
        end
    endtask

    task automatic check_hist(input string name, input hist_t expected, input hist_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %0t ns step %0d: %s expected %h, got %h",
                               $time, cur_step, name, expected, actual));
        end
    endtask

    function automatic xlen_t step_word(input int step, input int col);
        return test_mem[step*NCOLS + col];
    endfunction

    function automatic logic step_flag(input int step, input int col);
        return step_word(step, col) != '0;
    endfunction

    // steps run until the end marker in the first column
    function automatic int count_steps();
        int n;
        n = 0;
        while (n < MAX_STEPS && step_word(n, 0) != END_MARK)
            n++;
        return n;
    endfunction

    task automatic apply_step(input int s);
        if_pc_i        <= step_word(s, 0);
        if_inst_i      <= step_word(s, 1);
        ex_valid_i     <= step_flag(s, 2);
        ex_taken_i     <= step_flag(s, 3);
        ex_pdt_true_i  <= step_flag(s, 4);
        ex_pc_i        <= step_word(s, 5);
        ex_target_i    <= step_word(s, 6);
        ex_history_i   <= hist_t'(step_word(s, 7));
        ex_inst_i      <= step_word(s, 8);
        id_push_i      <= step_flag(s, 9);
        id_push_data_i <= step_word(s, 10);
        id_stall_i     <= step_flag(s, 11);
        ex_stall_i     <= step_flag(s, 12);
    endtask

    task automatic check_step(input int s);
        cur_step = s;
        check_bit("is_branch_o", step_flag(s, 13), is_branch_o);
        check_bit("pred_taken_o", step_flag(s, 14), pred_taken_o);
        check_addr("pred_pc_o", step_word(s, 15), pred_pc_o);
        check_hist("history_o", hist_t'(step_word(s, 16)), history_o);
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        wait (max_cycles > 0);
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        fail_run($sformatf("timeout: tests not finished after %0d clock cycles", cycle_cnt));
    end

    initial begin : main
        rst            = 1'b1;
        if_pc_i        = '0;
        if_inst_i      = '0;
        ex_valid_i     = 1'b0;
        ex_taken_i     = 1'b0;
        ex_pdt_true_i  = 1'b0;
        ex_stall_i     = 1'b0;
        ex_pc_i        = '0;
        ex_target_i    = '0;
        ex_inst_i      = '0;
        ex_history_i   = '0;
        id_push_i      = 1'b0;
        id_push_data_i = '0;
        id_stall_i     = 1'b0;
        cur_step       = 0;
        $readmemh("tb/bpu_tests.txt", test_mem);
        n_steps = count_steps();
        if (n_steps == 0 || n_steps == MAX_STEPS)
            fail_run("the tests file holds no steps or lacks its end marker");
        max_cycles = (n_steps + RESET_CYCLES) * 2;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int s = 0; s < n_steps; s++) begin
            @(posedge clk);
            apply_step(s);
            @(negedge clk);  // outputs settled mid-cycle
            check_step(s);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/bpu_tests.txt */
// if_pc if_inst | ex_valid ex_taken ex_pdt_true ex_pc ex_target ex_history ex_inst
// id_push id_push_data id_stall ex_stall | exp is_branch pred_taken pred_pc history
00000100 00000013 0 0 0 00000000 00000000 0000 00000000 0 00000000 0 0 0 0 00000104 0000
00000200 100000ef 1 1 1 00000200 00005000 0000 100000ef 0 00000000 0 0 1 1 00000300 0000
00000200 100000ef 0 0 0 00000000 00000000 0000 00000000 0 00000000 0 0 1 1 00005000 0001
00001000 04000063 1 1 0 00001000 00007000 0031 04000063 0 00000000 0 0 1 0 00001004 0001
00001000 04000063 1 0 1 00001000 00001004 0000 04000063 0 00000000 0 0 1 1 00007000 0003
00001000 04000063 1 0 1 00004008 0000400c 0000 04000063 0 00000000 0 0 1 0 00001004 0006
00001000 04000063 1 0 1 00004008 0000400c 0000 04000063 0 00000000 0 0 1 0 00001004 000c
00001000 04000063 1 1 1 00002002 0000a000 0000 04000063 0 00000000 0 0 1 0 00001004 0018
00001000 04000063 0 0 0 00000000 00000000 0000 00000000 0 00000000 0 0 1 1 00001040 0031
00003100 00008067 0 0 0 00000000 00000000 0000 00000000 0 00000000 0 0 1 0 00003104 0031
00000100 00000013 0 0 0 00000000 00000000 0000 00000000 1 00000604 0 0 0 0 00000104 0031
00003100 00008067 0 0 0 00000000 00000000 0000 00000000 0 00000000 0 0 1 1 00000604 0031
00003100 00008067 0 0 0 00000000 00000000 0000 00000000 1 00000a08 0 0 1 1 00000a08 0031
00003100 00008067 0 0 0 00000000 00000000 0000 00000000 1 dead0000 1 0 1 1 00000a08 0031
00003100 00008067 1 1 1 00003100 00000604 0000 00008067 1 beef0000 0 1 1 1 00000a08 0031
00003100 00008067 1 1 1 00003100 00000a08 0000 00008067 0 00000000 0 0 1 1 00000a08 0063
00003100 00008067 0 0 0 00000000 00000000 0000 00000000 0 00000000 0 0 1 1 00000604 00c7
00000100 00000013 1 1 1 00003100 00000604 0000 00008067 1 00000e0c 0 0 0 0 00000104 00c7
00003100 00008067 0 0 0 00000000 00000000 0000 00000000 0 00000000 0 0 1 1 00000e0c 018f
00003100 00008067 1 1 1 00003100 00000e0c 0000 00008067 0 00000000 0 0 1 1 00000e0c 018f
00003100 00008067 0 0 0 00000000 00000000 0000 00000000 0 00000000 0 0 1 0 00003104 031f
00000100 00000013 0 0 0 00000000 00000000 0000 00000000 0 00000000 0 0 0 0 00000104 031f
// end marker
ffffffff

/* bpu.f */
design/bpu_pkg.sv
design/bpu_update_if.sv
design/tagged_table.sv
design/direction_predictor.sv
design/btb.sv
design/return_stack.sv
design/bpu.sv
tb/bpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= bpu_tb
FILELIST  ?= bpu.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
